/* common/store_buffer_macros.svh */
// ------------------------------
// Store buffer sizing macros
// Data, byte-enable and ROB index widths plus the default entry count
// ------------------------------

`ifndef STORE_BUFFER_MACROS_SVH
`define STORE_BUFFER_MACROS_SVH

// Datapath
`define SB_XLEN 64
`define SB_BE_W 8

// ROB index width
`define SB_ROB_IDX_W 4

// Default number of store buffer entries
`define SB_DEPTH 4

`endif

/* common/store_buffer_pkg.sv */
// ------------------------------
// Store buffer types
// Widths, exception codes, entry states and the
// packed structs passed between the pipeline stages
// ------------------------------

`default_nettype none

`include "store_buffer_macros.svh"

package store_buffer_pkg;

  // Tag field wide enough for the default depth
  localparam int unsigned SB_TAG_W = $clog2(`SB_DEPTH);

  typedef logic [`SB_ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [SB_TAG_W-1:0] sb_tag_t;

  typedef enum logic [1:0] {
    LS_BYTE,
    LS_HALFWORD,
    LS_WORD,
    LS_DOUBLEWORD
  } ls_width_e;

  typedef enum logic [3:0] {
    EXC_NONE          = 4'd0,
    EXC_ST_MISALIGNED = 4'd6
  } except_code_e;

  // Per-entry state
  typedef enum logic [3:0] {
    SB_EMPTY,
    SB_RS12_PENDING,
    SB_RS1_PENDING,
    SB_RS2_PENDING,
    SB_ADDR_REQ,
    SB_ADDR_WAIT,
    SB_ROB_WAIT,
    SB_MEM_REQ,
    SB_MEM_WAIT,
    SB_COMPLETED
  } sb_state_e;

  typedef struct packed {
    logic                ready;
    rob_idx_t            rob_idx;  // Producer when not ready
    logic [`SB_XLEN-1:0] value;
  } operand_t;

  typedef struct packed {
    ls_width_e           width;
    operand_t            rs1;      // Base address
    operand_t            rs2;      // Store data
    logic [`SB_XLEN-1:0] imm;
    rob_idx_t            dest_rob_idx;
  } issue_req_t;

  typedef struct packed {
    rob_idx_t            rob_idx;
    logic [`SB_XLEN-1:0] value;
    logic                except_raised;
    except_code_e        except_code;
  } cdb_t;

  typedef struct packed {
    sb_tag_t             tag;
    logic [`SB_XLEN-1:0] base;
    logic [`SB_XLEN-1:0] offset;
    ls_width_e           width;
  } addr_req_t;

  typedef struct packed {
    sb_tag_t             tag;
    logic [`SB_XLEN-1:0] addr;
    logic                misaligned;
  } addr_ans_t;

  typedef struct packed {
    logic [`SB_XLEN-1:0] addr;
    logic [`SB_XLEN-1:0] wdata;
    logic [`SB_BE_W-1:0] be;
    sb_tag_t             tag;
  } mem_req_t;

endpackage

`default_nettype wire

/* store_buffer/sb_entry_table.sv */
// ------------------------------
// Store buffer entry table
// Circular queue of stores, one FSM per entry; head, tail,
// address and memory pointers pick the entry for each stage
// ------------------------------

`default_nettype none

`include "store_buffer_macros.svh"

module sb_entry_table
  import store_buffer_pkg::*;
#(
  parameter int unsigned DEPTH = `SB_DEPTH
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     flush_i,
  input  wire logic                     issue_valid_i,
  input  wire issue_req_t               issue_req_i,
  output logic                          issue_ready_o,
  input  wire logic                     cdb_valid_i,
  input  wire cdb_t                     cdb_i,
  input  wire logic [`SB_ROB_IDX_W-1:0] comm_rob_clear_idx_i,
  output logic                          addr_req_valid_o,
  output addr_req_t                     addr_req_o,
  input  wire logic                     addr_ans_valid_i,
  input  wire addr_ans_t                addr_ans_i,
  output logic                          mem_entry_valid_o,
  output mem_req_t                      mem_entry_o,
  input  wire logic                     mem_entry_ready_i,
  input  wire logic                     mem_valid_i,
  input  wire sb_tag_t                  mem_tag_i,
  output logic                          cdb_valid_o,
  input  wire logic                     cdb_ready_i,
  output cdb_t                          cdb_o
);

  localparam int unsigned IdxW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  if (IdxW > SB_TAG_W) begin : gen_depth_check
    $error("DEPTH needs a wider tag than the package provides");
  end

  typedef struct packed {
    ls_width_e           width;
    rob_idx_t            rs1_rob_idx;
    logic [`SB_XLEN-1:0] rs1_value;
    rob_idx_t            rs2_rob_idx;
    logic [`SB_XLEN-1:0] rs2_value;
    rob_idx_t            dest_rob_idx;
    logic [`SB_XLEN-1:0] imm_addr;     // Offset, later the address
    logic                misaligned;
  } entry_t;

  entry_t    [DEPTH-1:0] entry_q;
  sb_state_e [DEPTH-1:0] state_q, state_d;
  logic      [IdxW-1:0]  head_q, tail_q, addr_q, mem_q;

  logic                push, pop, addr_fire, mem_fire, mem_skip;
  logic                iss_rs1_hit, iss_rs2_hit;
  sb_state_e           issue_state;
  logic [IdxW-1:0]     ans_idx, resp_idx;
  logic [DEPTH-1:0]    hit_rs1, hit_rs2, rob_go;
  logic [`SB_BE_W-1:0] be_mask;

  function automatic logic [IdxW-1:0] ptr_inc(input logic [IdxW-1:0] ptr);
    ptr_inc = (ptr == IdxW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push      = issue_valid_i & issue_ready_o;
  assign pop       = cdb_valid_o & cdb_ready_i;
  assign addr_fire = addr_req_valid_o;                  // Address stage never stalls
  assign mem_fire  = mem_entry_valid_o & mem_entry_ready_i;
  assign mem_skip  = state_q[mem_q] == SB_COMPLETED;    // Misaligned, no write
  assign ans_idx   = IdxW'(addr_ans_i.tag);
  assign resp_idx  = IdxW'(mem_tag_i);

  // Operand arriving on the CDB in the issue cycle
  assign iss_rs1_hit = cdb_valid_i & ~issue_req_i.rs1.ready &
                       (cdb_i.rob_idx == issue_req_i.rs1.rob_idx);
  assign iss_rs2_hit = cdb_valid_i & ~issue_req_i.rs2.ready &
                       (cdb_i.rob_idx == issue_req_i.rs2.rob_idx);

  always_comb begin : p_issue_state
    case ({issue_req_i.rs1.ready | iss_rs1_hit, issue_req_i.rs2.ready | iss_rs2_hit})
      2'b11:   issue_state = SB_ADDR_REQ;
      2'b10:   issue_state = SB_RS2_PENDING;
      2'b01:   issue_state = SB_RS1_PENDING;
      default: issue_state = SB_RS12_PENDING;
    endcase
  end

  always_comb begin : p_match
    for (int i = 0; i < DEPTH; i++) begin
      hit_rs1[i] = cdb_valid_i & (cdb_i.rob_idx == entry_q[i].rs1_rob_idx);
      hit_rs2[i] = cdb_valid_i & (cdb_i.rob_idx == entry_q[i].rs2_rob_idx);
      rob_go[i]  = comm_rob_clear_idx_i == entry_q[i].dest_rob_idx;
    end
  end

  // ------------------------------
  // Entry FSMs
  // ------------------------------
  always_comb begin : p_next_state
    state_d = state_q;
    for (int i = 0; i < DEPTH; i++) begin
      case (state_q[i])
        SB_EMPTY: if (push && tail_q == IdxW'(i)) state_d[i] = issue_state;
        SB_RS12_PENDING: begin
          if (hit_rs1[i] && hit_rs2[i]) state_d[i] = SB_ADDR_REQ;
          else if (hit_rs1[i]) state_d[i] = SB_RS2_PENDING;
          else if (hit_rs2[i]) state_d[i] = SB_RS1_PENDING;
        end
        SB_RS1_PENDING: if (hit_rs1[i]) state_d[i] = SB_ADDR_REQ;
        SB_RS2_PENDING: if (hit_rs2[i]) state_d[i] = SB_ADDR_REQ;
        SB_ADDR_REQ: if (addr_fire && addr_q == IdxW'(i)) state_d[i] = SB_ADDR_WAIT;
        SB_ADDR_WAIT: begin
          if (addr_ans_valid_i && ans_idx == IdxW'(i)) begin
            if (addr_ans_i.misaligned) state_d[i] = SB_COMPLETED;
            else if (rob_go[i]) state_d[i] = SB_MEM_REQ;
            else state_d[i] = SB_ROB_WAIT;
          end
        end
        SB_ROB_WAIT: if (rob_go[i]) state_d[i] = SB_MEM_REQ;
        SB_MEM_REQ: if (mem_fire && mem_q == IdxW'(i)) state_d[i] = SB_MEM_WAIT;
        SB_MEM_WAIT: if (mem_valid_i && resp_idx == IdxW'(i)) state_d[i] = SB_COMPLETED;
        SB_COMPLETED: if (pop && head_q == IdxW'(i)) state_d[i] = SB_EMPTY;
        default: state_d[i] = SB_EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= {DEPTH{SB_EMPTY}};
    end else if (flush_i) begin
      state_q <= {DEPTH{SB_EMPTY}};
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptrs
    if (!rst_ni) begin
      head_q <= '0;
      tail_q <= '0;
      addr_q <= '0;
      mem_q  <= '0;
    end else if (flush_i) begin
      head_q <= '0;
      tail_q <= '0;
      addr_q <= '0;
      mem_q  <= '0;
    end else begin
      if (pop) head_q <= ptr_inc(head_q);
      if (push) tail_q <= ptr_inc(tail_q);
      if (addr_fire) addr_q <= ptr_inc(addr_q);
      if (mem_fire || mem_skip) mem_q <= ptr_inc(mem_q);
    end
  end

  // ------------------------------
  // Entry payload
  // ------------------------------
  always_ff @(posedge clk_i) begin : p_payload
    for (int i = 0; i < DEPTH; i++) begin
      if (state_q[i] == SB_EMPTY && push && tail_q == IdxW'(i)) begin
        entry_q[i].width        <= issue_req_i.width;
        entry_q[i].rs1_rob_idx  <= issue_req_i.rs1.rob_idx;
        entry_q[i].rs1_value    <= iss_rs1_hit ? cdb_i.value : issue_req_i.rs1.value;
        entry_q[i].rs2_rob_idx  <= issue_req_i.rs2.rob_idx;
        entry_q[i].rs2_value    <= iss_rs2_hit ? cdb_i.value : issue_req_i.rs2.value;
        entry_q[i].dest_rob_idx <= issue_req_i.dest_rob_idx;
        entry_q[i].imm_addr     <= issue_req_i.imm;
        entry_q[i].misaligned   <= 1'b0;
      end
      if (hit_rs1[i] && (state_q[i] == SB_RS12_PENDING || state_q[i] == SB_RS1_PENDING)) begin
        entry_q[i].rs1_value <= cdb_i.value;
      end
      if (hit_rs2[i] && (state_q[i] == SB_RS12_PENDING || state_q[i] == SB_RS2_PENDING)) begin
        entry_q[i].rs2_value <= cdb_i.value;
      end
      if (state_q[i] == SB_ADDR_WAIT && addr_ans_valid_i && ans_idx == IdxW'(i)) begin
        entry_q[i].imm_addr   <= addr_ans_i.addr;
        entry_q[i].misaligned <= addr_ans_i.misaligned;
      end
    end
  end

  // ------------------------------
  // Stage outputs
  // ------------------------------
  assign issue_ready_o = state_q[tail_q] == SB_EMPTY;

  assign addr_req_valid_o  = state_q[addr_q] == SB_ADDR_REQ;
  assign addr_req_o.tag    = sb_tag_t'(addr_q);
  assign addr_req_o.base   = entry_q[addr_q].rs1_value;
  assign addr_req_o.offset = entry_q[addr_q].imm_addr;
  assign addr_req_o.width  = entry_q[addr_q].width;

  // Byte mask at lane zero
  always_comb begin : p_be_mask
    case (entry_q[mem_q].width)
      LS_BYTE:     be_mask = 8'h01;
      LS_HALFWORD: be_mask = 8'h03;
      LS_WORD:     be_mask = 8'h0f;
      default:     be_mask = 8'hff;
    endcase
  end

  assign mem_entry_valid_o = state_q[mem_q] == SB_MEM_REQ;
  assign mem_entry_o.addr  = entry_q[mem_q].imm_addr;
  assign mem_entry_o.wdata = entry_q[mem_q].rs2_value;
  assign mem_entry_o.be    = be_mask;
  assign mem_entry_o.tag   = sb_tag_t'(mem_q);

  // Address goes out as the result value
  assign cdb_valid_o         = state_q[head_q] == SB_COMPLETED;
  assign cdb_o.rob_idx       = entry_q[head_q].dest_rob_idx;
  assign cdb_o.value         = entry_q[head_q].imm_addr;
  assign cdb_o.except_raised = entry_q[head_q].misaligned;
  assign cdb_o.except_code   = entry_q[head_q].misaligned ? EXC_ST_MISALIGNED : EXC_NONE;

  // ------------------------------
  // Assertions
  // ------------------------------
  // Tail only meets a busy entry when the ring is full
  a_tail_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q[tail_q] != SB_EMPTY |-> tail_q == head_q)
    else $error("Tail entry %0d in use while head is entry %0d", tail_q, head_q);

  // Response must belong to an outstanding write
  a_resp_tag : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid_i && !flush_i |-> state_q[resp_idx] == SB_MEM_WAIT)
    else $error("Memory response for entry %0d not in memory wait", resp_idx);

endmodule

`default_nettype wire

/* store_buffer/sb_addr_gen.sv */
// ------------------------------
// Store address stage
// Base plus offset, registered for one cycle, with a check
// of the low address bits against the access width
// ------------------------------

`default_nettype none

`include "store_buffer_macros.svh"

module sb_addr_gen
  import store_buffer_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      flush_i,
  input  wire logic      req_valid_i,
  input  wire addr_req_t req_i,
  output logic           ans_valid_o,
  output addr_ans_t      ans_o
);

  logic [`SB_XLEN-1:0] sum;
  logic                misaligned;

  assign sum = req_i.base + req_i.offset;

  always_comb begin : p_align
    case (req_i.width)
      LS_HALFWORD:   misaligned = sum[0];
      LS_WORD:       misaligned = |sum[1:0];
      LS_DOUBLEWORD: misaligned = |sum[2:0];
      default:       misaligned = 1'b0;           // Bytes always fit
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      ans_valid_o <= 1'b0;
    end else begin
      ans_valid_o <= req_valid_i & ~flush_i;      // Flush drops the answer
    end
  end

  always_ff @(posedge clk_i) begin : p_ans
    if (req_valid_i) begin
      ans_o.tag        <= req_i.tag;
      ans_o.addr       <= sum;
      ans_o.misaligned <= misaligned;
    end
  end

endmodule

`default_nettype wire

/* store_buffer/sb_mem_port.sv */
// ------------------------------
// Store memory port
// Output register for write requests; moves byte enables
// and data onto the lanes picked by the low address bits
// ------------------------------

`default_nettype none

`include "store_buffer_macros.svh"

module sb_mem_port
  import store_buffer_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     flush_i,
  input  wire logic     entry_valid_i,
  input  wire mem_req_t entry_i,
  output logic          entry_ready_o,
  output logic          mem_valid_o,
  input  wire logic     mem_ready_i,
  output mem_req_t      mem_req_o
);

  logic [`SB_BE_W-1:0] be_placed;
  logic [`SB_XLEN-1:0] wdata_placed;

  // Lane placement inside the doubleword
  assign be_placed    = entry_i.be << entry_i.addr[2:0];
  assign wdata_placed = entry_i.wdata << {entry_i.addr[2:0], 3'b000};

  // Empty, or draining this cycle
  assign entry_ready_o = ~mem_valid_o | mem_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      mem_valid_o <= 1'b0;
    end else if (flush_i) begin
      mem_valid_o <= 1'b0;
    end else if (entry_ready_o) begin
      mem_valid_o <= entry_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_req
    if (entry_valid_i && entry_ready_o) begin
      mem_req_o.addr  <= entry_i.addr;
      mem_req_o.wdata <= wdata_placed;
      mem_req_o.be    <= be_placed;
      mem_req_o.tag   <= entry_i.tag;
    end
  end

  // ------------------------------
  // Assertions
  // ------------------------------
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_valid_o && !mem_ready_i && !flush_i |=> mem_valid_o && $stable(mem_req_o))
    else $error("Memory request changed while stalled");

endmodule

`default_nettype wire

/* store_buffer/store_buffer.sv */
// ------------------------------
// Store buffer top level
// Entry table, address stage and memory port in a pipeline
// ------------------------------

`default_nettype none

`include "store_buffer_macros.svh"

module store_buffer
  import store_buffer_pkg::*;
#(
  parameter int unsigned DEPTH = `SB_DEPTH
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     flush_i,
  // Issue
  input  wire logic                     issue_valid_i,
  input  wire issue_req_t               issue_req_i,
  output logic                          issue_ready_o,
  // CDB in
  input  wire logic                     cdb_valid_i,
  input  wire cdb_t                     cdb_i,
  // Commit
  input  wire logic [`SB_ROB_IDX_W-1:0] comm_rob_clear_idx_i,
  // Memory
  output logic                          mem_valid_o,
  input  wire logic                     mem_ready_i,
  output mem_req_t                      mem_req_o,
  input  wire logic                     mem_valid_i,
  input  wire sb_tag_t                  mem_tag_i,
  // CDB out
  output logic                          cdb_valid_o,
  input  wire logic                     cdb_ready_i,
  output cdb_t                          cdb_o
);

  // ------------------------------
  // Stage links
  // ------------------------------
  logic      addr_req_valid;
  addr_req_t addr_req;
  logic      addr_ans_valid;
  addr_ans_t addr_ans;
  logic      mem_entry_valid;
  logic      mem_entry_ready;
  mem_req_t  mem_entry;           // Unshifted lanes

  sb_entry_table #(
    .DEPTH(DEPTH)
  ) i_entry_table (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .issue_valid_i       (issue_valid_i),
    .issue_req_i         (issue_req_i),
    .issue_ready_o       (issue_ready_o),
    .cdb_valid_i         (cdb_valid_i),
    .cdb_i               (cdb_i),
    .comm_rob_clear_idx_i(comm_rob_clear_idx_i),
    .addr_req_valid_o    (addr_req_valid),
    .addr_req_o          (addr_req),
    .addr_ans_valid_i    (addr_ans_valid),
    .addr_ans_i          (addr_ans),
    .mem_entry_valid_o   (mem_entry_valid),
    .mem_entry_o         (mem_entry),
    .mem_entry_ready_i   (mem_entry_ready),
    .mem_valid_i         (mem_valid_i),
    .mem_tag_i           (mem_tag_i),
    .cdb_valid_o         (cdb_valid_o),
    .cdb_ready_i         (cdb_ready_i),
    .cdb_o               (cdb_o)
  );

  sb_addr_gen i_addr_gen (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .req_valid_i(addr_req_valid),
    .req_i      (addr_req),
    .ans_valid_o(addr_ans_valid),
    .ans_o      (addr_ans)
  );

  sb_mem_port i_mem_port (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .entry_valid_i(mem_entry_valid),
    .entry_i      (mem_entry),
    .entry_ready_o(mem_entry_ready),
    .mem_valid_o  (mem_valid_o),
    .mem_ready_i  (mem_ready_i),
    .mem_req_o    (mem_req_o)
  );

endmodule

`default_nettype wire

/* bench/tb_store_buffer.sv */
// ------------------------------
// Store buffer testbench
// Reference model, memory model with random stalls and
// in-order checks of memory writes and CDB reports
// ------------------------------

`default_nettype none

`include "store_buffer_macros.svh"

module tb_store_buffer
  import store_buffer_pkg::*;
();

  localparam int DEPTH = `SB_DEPTH;
  localparam int N_STORES = 28;          // Stores issued over all tests
  localparam rob_idx_t RS1_PROD = 4'hA;  // Producers of pending operands
  localparam rob_idx_t RS2_PROD = 4'hB;

  typedef struct packed {
    mem_req_t mem;
    cdb_t     cdb;
    logic     writes;
  } exp_t;

  logic       clk = 1'b0;
  logic       rst_n = 1'b0;
  logic       flush = 1'b0;
  logic       issue_valid = 1'b0;
  issue_req_t issue_req = '0;
  logic       issue_ready;
  logic       cdb_in_valid = 1'b0;
  cdb_t       cdb_in = '0;
  rob_idx_t   comm_idx = '0;
  logic       mem_valid;
  logic       mem_ready = 1'b0;
  mem_req_t   mem_req;
  logic       mem_resp_valid = 1'b0;
  sb_tag_t    mem_resp_tag = '0;
  logic       cdb_valid;
  logic       cdb_ready = 1'b0;
  cdb_t       cdb_out;

  int          errors = 0;
  int          test_errors = 0;
  int          checks = 0;
  int          cycle = 0;
  int          last_due = 0;
  logic        commit_hold = 1'b0;
  rob_idx_t    next_rob = '0;
  sb_tag_t     slot = '0;           // Entry the next store lands in
  logic [31:0] stim_rng = 32'h73c4f189;
  logic [31:0] mem_rng = 32'h73c4f189;
  mem_req_t    exp_mem_q[$];
  cdb_t        exp_cdb_q[$];
  sb_tag_t     resp_tag_q[$];
  int          resp_due_q[$];
  logic        mem_held = 1'b0;
  logic        cdb_held = 1'b0;
  mem_req_t    held_mem;
  cdb_t        held_cdb;

  store_buffer i_dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .flush_i             (flush),
    .issue_valid_i       (issue_valid),
    .issue_req_i         (issue_req),
    .issue_ready_o       (issue_ready),
    .cdb_valid_i         (cdb_in_valid),
    .cdb_i               (cdb_in),
    .comm_rob_clear_idx_i(comm_idx),
    .mem_valid_o         (mem_valid),
    .mem_ready_i         (mem_ready),
    .mem_req_o           (mem_req),
    .mem_valid_i         (mem_resp_valid),
    .mem_tag_i           (mem_resp_tag),
    .cdb_valid_o         (cdb_valid),
    .cdb_ready_i         (cdb_ready),
    .cdb_o               (cdb_out)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Expected write and report for one store
  function automatic exp_t ref_store(input ls_width_e w, input logic [63:0] base,
                                     input logic [63:0] imm, input logic [63:0] data,
                                     input rob_idx_t dest, input sb_tag_t tag);
    exp_t        e;
    logic [63:0] addr;
    logic [7:0]  be0;
    logic        mis;
    addr = base + imm;
    case (w)
      LS_BYTE:     be0 = 8'h01;
      LS_HALFWORD: be0 = 8'h03;
      LS_WORD:     be0 = 8'h0f;
      default:     be0 = 8'hff;
    endcase
    mis = |(addr[2:0] & {be0[7], be0[3], be0[1]});  // Low bits covered by the size
    e.mem.addr = addr;
    e.mem.wdata = data << (8 * addr[2:0]);
    e.mem.be = be0 << addr[2:0];
    e.mem.tag = tag;
    e.cdb.rob_idx = dest;
    e.cdb.value = addr;
    e.cdb.except_raised = mis;
    e.cdb.except_code = mis ? EXC_ST_MISALIGNED : EXC_NONE;
    e.writes = !mis;
    return e;
  endfunction

  task automatic report_error(input string what);
    errors++;
    test_errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic check_mem(input string name, input mem_req_t got, input mem_req_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cdb(input string name, input cdb_t got, input cdb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic issue_store(input ls_width_e w, input logic [63:0] base,
                             input logic [63:0] imm, input logic [63:0] data,
                             input logic rs1_rdy, input logic rs2_rdy);
    issue_req_t req;
    exp_t       e;
    req.width = w;
    req.rs1.ready = rs1_rdy;
    req.rs1.rob_idx = RS1_PROD;
    req.rs1.value = rs1_rdy ? base : ~base;  // Junk until broadcast
    req.rs2.ready = rs2_rdy;
    req.rs2.rob_idx = RS2_PROD;
    req.rs2.value = rs2_rdy ? data : ~data;
    req.imm = imm;
    req.dest_rob_idx = next_rob;
    e = ref_store(w, base, imm, data, next_rob, slot);
    issue_valid = 1'b1;
    issue_req = req;
    do @(posedge clk); while (issue_ready !== 1'b1);
    if (e.writes) exp_mem_q.push_back(e.mem);
    exp_cdb_q.push_back(e.cdb);
    next_rob++;
    slot = (slot == sb_tag_t'(DEPTH - 1)) ? '0 : slot + 1'b1;
    #1;
    issue_valid = 1'b0;
  endtask

  // Aligned store of random width and lane
  task automatic issue_random();
    logic [63:0] base;
    logic [63:0] imm;
    logic [63:0] data;
    logic [2:0]  lane;
    ls_width_e   w;
    stim_rng = xorshift(stim_rng);
    w = ls_width_e'(stim_rng[1:0]);
    base = {stim_rng, stim_rng ^ 32'h5a5a5a5a} & ~64'h7;
    stim_rng = xorshift(stim_rng);
    lane = stim_rng[2:0] & 3'(3'b111 << w);
    imm = {32'h0, stim_rng[31:3], lane};
    stim_rng = xorshift(stim_rng);
    data = {stim_rng, ~stim_rng};
    issue_store(w, base, imm, data, 1'b1, 1'b1);
  endtask

  task automatic broadcast(input rob_idx_t idx, input logic [63:0] value);
    cdb_in_valid = 1'b1;
    cdb_in = '0;
    cdb_in.rob_idx = idx;
    cdb_in.value = value;
    @(posedge clk);
    #1;
    cdb_in_valid = 1'b0;
  endtask

  task automatic expect_idle(input int cycles, input string why);
    repeat (cycles) begin
      @(posedge clk);
      if (mem_valid || cdb_valid) report_error(why);
    end
    #1;
  endtask

  // Wait until every issued store has reported
  task automatic drain();
    do @(posedge clk); while (exp_cdb_q.size() != 0);
    #1;
    if (exp_mem_q.size() != 0) begin
      report_error("memory write missing for a reported store");
      exp_mem_q.delete();
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %-30s %0d errors", num, name, test_errors);
    test_errors = 0;
  endtask

  // ------------------------------
  // Memory model and random stalls
  // ------------------------------
  always @(posedge clk) begin : p_mem_model
    int due;
    cycle++;
    if (flush || !rst_n) begin
      resp_tag_q.delete();
      resp_due_q.delete();
    end else if (mem_valid && mem_ready) begin
      mem_rng = xorshift(mem_rng);
      due = cycle + 1 + int'(mem_rng[1:0]);  // 1 to 4 cycles, in order
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      resp_tag_q.push_back(mem_req.tag);
      resp_due_q.push_back(due);
    end
    #1;
    mem_rng = xorshift(mem_rng);
    mem_ready = mem_rng[1:0] != 2'd0;
    cdb_ready = mem_rng[4:3] != 2'd0;
    mem_resp_valid = 1'b0;
    if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle + 1) begin
      mem_resp_valid = 1'b1;
      mem_resp_tag = resp_tag_q.pop_front();
      void'(resp_due_q.pop_front());
    end
  end

  // Commit follows the oldest unreported store
  always @(posedge clk) begin : p_commit
    #1;
    if (exp_cdb_q.size() != 0) comm_idx = exp_cdb_q[0].rob_idx + (commit_hold ? 4'd8 : 4'd0);
  end

  always @(posedge clk) begin : p_compare
    if (rst_n && !flush) begin
      if (mem_held && !mem_valid) report_error("memory request dropped while stalled");
      if (mem_held && mem_valid) check_mem("mem_req_o", mem_req, held_mem);
      if (cdb_held && !cdb_valid) report_error("CDB report dropped while stalled");
      if (cdb_held && cdb_valid) check_cdb("cdb_o", cdb_out, held_cdb);
      if (mem_valid && mem_ready) begin
        if (exp_mem_q.size() == 0) report_error("unexpected memory write");
        else check_mem("mem_req_o", mem_req, exp_mem_q.pop_front());
      end
      if (cdb_valid && cdb_ready) begin
        if (exp_cdb_q.size() == 0) report_error("unexpected CDB report");
        else check_cdb("cdb_o", cdb_out, exp_cdb_q.pop_front());
      end
      mem_held = mem_valid && !mem_ready;
      cdb_held = cdb_valid && !cdb_ready;
      held_mem = mem_req;
      held_cdb = cdb_out;
    end else begin
      mem_held = 1'b0;
      cdb_held = 1'b0;
    end
  end

  initial begin : p_watchdog
    #((N_STORES * 200 + 20) * 10);
    $display("Timeout: stores still outstanding after %0d cycles", cycle);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : p_stimulus
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (issue_ready !== 1'b1) report_error("issue_ready_o low after reset");
    expect_idle(2, "output active after reset");

    issue_store(LS_BYTE, 64'h1000, 64'h5, 64'h1122_3344_5566_7788, 1'b1, 1'b1);
    issue_store(LS_HALFWORD, 64'h2000, 64'h6, 64'h0123_4567_89ab_cdef, 1'b1, 1'b1);
    issue_store(LS_WORD, 64'h3000, 64'h4, 64'hdead_beef_0bad_f00d, 1'b1, 1'b1);
    issue_store(LS_DOUBLEWORD, 64'h4000, 64'h8, 64'hfeed_face_cafe_babe, 1'b1, 1'b1);
    drain();
    end_test(1, "ready operands, all widths");

    issue_store(LS_WORD, 64'h5000, 64'h8, 64'h0000_0000_cafe_f00d, 1'b0, 1'b1);
    expect_idle(6, "memory write before rs1 arrived");
    broadcast(RS1_PROD, 64'h5000);
    drain();
    issue_store(LS_DOUBLEWORD, 64'h5100, 64'h10, 64'h0f0e_0d0c_0b0a_0908, 1'b1, 1'b0);
    expect_idle(6, "memory write before rs2 arrived");
    broadcast(RS2_PROD, 64'h0f0e_0d0c_0b0a_0908);
    drain();
    issue_store(LS_HALFWORD, 64'h5200, 64'h2, 64'h0000_0000_0000_a55a, 1'b0, 1'b0);
    expect_idle(4, "memory write before operands arrived");
    broadcast(RS2_PROD, 64'h0000_0000_0000_a55a);
    expect_idle(3, "memory write before rs1 arrived");
    broadcast(RS1_PROD, 64'h5200);
    drain();
    end_test(2, "pending operands");

    commit_hold = 1'b1;
    repeat (DEPTH) issue_random();
    @(posedge clk);
    if (issue_ready !== 1'b0) report_error("issue_ready_o stayed high with every entry in use");
    #1;
    commit_hold = 1'b0;
    repeat (12 - DEPTH) issue_random();
    drain();
    end_test(3, "ordering under back-pressure");

    issue_store(LS_HALFWORD, 64'h6000, 64'h1, 64'h1111, 1'b1, 1'b1);
    issue_store(LS_WORD, 64'h6002, 64'h0, 64'h2222, 1'b1, 1'b1);
    issue_store(LS_DOUBLEWORD, 64'h6000, 64'h4, 64'h3333, 1'b1, 1'b1);
    drain();
    end_test(4, "misaligned addresses");

    commit_hold = 1'b1;
    issue_store(LS_DOUBLEWORD, 64'h7000, 64'h10, 64'h7777_8888_9999_aaaa, 1'b1, 1'b1);
    expect_idle(20, "memory write before commit");
    commit_hold = 1'b0;
    drain();
    end_test(5, "commit gating");

    // Stores wait on rs1, which only arrives after the flush
    issue_store(LS_WORD, 64'h8000, 64'h0, 64'h1234_5678, 1'b0, 1'b1);
    issue_store(LS_DOUBLEWORD, 64'h8000, 64'h8, 64'h8765_4321, 1'b0, 1'b1);
    issue_store(LS_BYTE, 64'h8000, 64'h13, 64'h9a, 1'b0, 1'b1);
    expect_idle(5, "memory write before rs1 arrived");
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    exp_mem_q.delete();
    exp_cdb_q.delete();
    slot = '0;
    broadcast(RS1_PROD, 64'h8000);
    expect_idle(20, "output for a flushed store");
    repeat (2) issue_random();
    drain();
    end_test(6, "flush");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* store_buffer.f */
+incdir+common
common/store_buffer_pkg.sv
store_buffer/sb_entry_table.sv
store_buffer/sb_addr_gen.sv
store_buffer/sb_mem_port.sv
store_buffer/store_buffer.sv
bench/tb_store_buffer.sv

/* Makefile */
SRCS = $(filter-out +incdir%,$(shell cat store_buffer.f)) common/store_buffer_macros.svh

obj_dir/Vtb_store_buffer: store_buffer.f $(SRCS)
	verilator --binary --timing --assert -f store_buffer.f --top-module tb_store_buffer \
		-o Vtb_store_buffer

run: obj_dir/Vtb_store_buffer
	./obj_dir/Vtb_store_buffer | tee sim.log
	grep -q "^ALL TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
